// File: hdl/wd_defs.svh
// ------------------------------
// watchdog sizes, widths and config
// register addresses
// ------------------------------
`ifndef WD_DEFS_SVH
`define WD_DEFS_SVH

// number of consumer queues watched by the hardware
`define WD_NUM_CQ 16
// width of a CQ number, log2 of the CQ count
`define WD_CQ_W 4

// idle counter and threshold width
`define WD_TIMER_W 8
// tick divider width, a tick comes every prescale+1 cycles
`define WD_PRESCALE_W 4

// config write port layout
`define WD_ADDR_W 2
`define WD_CFG_DATA_W 16

// register map of the config port
`define WD_ADDR_THRESH 2'd0
`define WD_ADDR_ENABLE 2'd1
`define WD_ADDR_PRESCALE 2'd2

`endif

// File: hdl/wd_pkg.sv
// ------------------------------
// watchdog types: vectors, config
// write struct, transfer FSM states
// ------------------------------
`default_nettype none

`include "wd_defs.svh"

package wd_pkg;

  // one bit per CQ, used for activity, enables, expiries and status
  typedef logic [`WD_NUM_CQ-1:0] cq_vec_t;

  // a single CQ number
  typedef logic [`WD_CQ_W-1:0] cq_idx_t;

  // idle count and expiry threshold
  typedef logic [`WD_TIMER_W-1:0] wd_count_t;

  // tick divider setting
  typedef logic [`WD_PRESCALE_W-1:0] prescale_t;

  // one config write, the strobe qualifies address and data
  typedef struct packed {
    logic                      wr;
    logic [`WD_ADDR_W-1:0]     addr;
    logic [`WD_CFG_DATA_W-1:0] data;
  } cfg_wr_t;

  // source side of the expiry transfer
  typedef enum logic [1:0] {
    IDLE,
    HOLD,
    DRAIN
  } xfer_state_t;

endpackage

`default_nettype wire

// File: hdl/wd_rr_arb.sv
// ------------------------------
// round-robin arbiter over the CQ
// request vector
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wd_defs.svh"

module wd_rr_arb (
  input  logic            clk,
  input  logic            rst_n,
  input  wd_pkg::cq_vec_t reqs,
  input  logic            update,
  output logic            winner_v,
  output wd_pkg::cq_idx_t winner
);

  import wd_pkg::*;

  // position with the highest priority for the next pick
  cq_idx_t ptr_q;

  // scan from the pointer upward and wrap around
  // the CQ count is a power of two, so the index add wraps by itself
  always_comb begin
    cq_idx_t idx;
    winner_v = 1'b0;
    winner   = '0;
    idx      = '0;
    for (int i = 0; i < `WD_NUM_CQ; i++) begin
      idx = ptr_q + cq_idx_t'(i);
      // first request found keeps the grant
      if (!winner_v && reqs[idx]) begin
        winner_v = 1'b1;
        winner   = idx;
      end
    end
  end

  // after a grant the winner drops to the lowest priority
  // this keeps a burst of expiries from starving high CQ numbers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (update && winner_v) begin
      ptr_q <= winner + cq_idx_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: hdl/wd_cfg_regs.sv
// ------------------------------
// pgcb config registers: threshold,
// enable mask and tick prescale
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wd_defs.svh"

module wd_cfg_regs (
  input  logic              hqm_pgcb_clk,
  input  logic              hqm_pgcb_rst_n,
  input  wd_pkg::cfg_wr_t   cfg,
  output wd_pkg::wd_count_t threshold,
  output wd_pkg::cq_vec_t   enable_mask,
  output wd_pkg::prescale_t prescale
);

  import wd_pkg::*;

  // ------------------------------
  // register writes
  // ------------------------------

  // a write updates the addressed register on the next edge
  // threshold 0 after reset keeps every timer stopped
  always_ff @(posedge hqm_pgcb_clk or negedge hqm_pgcb_rst_n) begin
    if (!hqm_pgcb_rst_n) begin
      threshold   <= '0;
      enable_mask <= '0;
      prescale    <= '0;
    end else if (cfg.wr) begin
      case (cfg.addr)
        `WD_ADDR_THRESH: begin
          threshold <= cfg.data[`WD_TIMER_W-1:0];
        end
        `WD_ADDR_ENABLE: begin
          enable_mask <= cfg.data[`WD_NUM_CQ-1:0];
        end
        `WD_ADDR_PRESCALE: begin
          prescale <= cfg.data[`WD_PRESCALE_W-1:0];
        end
        default: begin
          // unmapped address, nothing changes
        end
      endcase
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // software only ever targets the three mapped registers
  a_cfg_addr_mapped: assert property (
    @(posedge hqm_pgcb_clk) disable iff (!hqm_pgcb_rst_n)
    cfg.wr |-> (cfg.addr <= `WD_ADDR_PRESCALE)
  );

endmodule

`default_nettype wire

// File: hdl/wd_cq_timers.sv
// ------------------------------
// per-CQ idle timers and prescale
// tick, one expiry pulse per CQ
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wd_defs.svh"

module wd_cq_timers (
  input  logic              hqm_pgcb_clk,
  input  logic              hqm_pgcb_rst_n,
  input  wd_pkg::wd_count_t threshold,
  input  wd_pkg::cq_vec_t   enable_mask,
  input  wd_pkg::prescale_t prescale,
  input  wd_pkg::cq_vec_t   cq_activity,
  output wd_pkg::cq_vec_t   expiry
);

  import wd_pkg::*;

  prescale_t pre_cnt_q;
  logic      tick;
  wd_count_t count_q   [`WD_NUM_CQ];
  wd_count_t count_nxt [`WD_NUM_CQ];
  cq_vec_t   expiry_nxt;

  // ------------------------------
  // prescale tick
  // ------------------------------

  // the compare is >= so a smaller prescale written mid-count
  // still ends the current period instead of wrapping the counter
  assign tick = (pre_cnt_q >= prescale);

  always_ff @(posedge hqm_pgcb_clk or negedge hqm_pgcb_rst_n) begin
    if (!hqm_pgcb_rst_n) begin
      pre_cnt_q <= '0;
    end else if (tick) begin
      pre_cnt_q <= '0;
    end else begin
      pre_cnt_q <= pre_cnt_q + prescale_t'(1);
    end
  end

  // ------------------------------
  // idle counters
  // ------------------------------

  always_comb begin
    for (int i = 0; i < `WD_NUM_CQ; i++) begin
      count_nxt[i]  = count_q[i];
      expiry_nxt[i] = 1'b0;
      // activity, a disabled CQ or a zero threshold restart the count
      if (!enable_mask[i] || cq_activity[i] || (threshold == '0)) begin
        count_nxt[i] = '0;
      end else if (tick) begin
        // count reaches the threshold on this tick, flag it for next cycle
        if (wd_count_t'(count_q[i] + 1'b1) >= threshold) begin
          count_nxt[i]  = '0;
          expiry_nxt[i] = 1'b1;
        end else begin
          count_nxt[i] = count_q[i] + 1'b1;
        end
      end
    end
  end

  // expiry is registered, so it shows one cycle after the tick
  always_ff @(posedge hqm_pgcb_clk or negedge hqm_pgcb_rst_n) begin
    if (!hqm_pgcb_rst_n) begin
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        count_q[i] <= '0;
      end
      expiry <= '0;
    end else begin
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        count_q[i] <= count_nxt[i];
      end
      expiry <= expiry_nxt;
    end
  end

  // an expiry only comes from a CQ that was enabled on the tick before it
  a_no_expiry_when_disabled: assert property (
    @(posedge hqm_pgcb_clk) disable iff (!hqm_pgcb_rst_n)
    (expiry & ~$past(enable_mask)) == '0
  );

endmodule

`default_nettype wire

// File: hdl/wd_expiry_xfer.sv
// ------------------------------
// expiry transfer pgcb to gated:
// pending, round-robin, level handshake
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module wd_expiry_xfer (
  input  logic            hqm_pgcb_clk,
  input  logic            hqm_pgcb_rst_n,
  input  logic            hqm_gated_clk,
  input  logic            hqm_gated_rst_n,
  input  wd_pkg::cq_vec_t expiry,
  input  logic            flr_prep,
  output logic            wd_clkreq,
  output wd_pkg::cq_vec_t cq_expiry_dest
);

  import wd_pkg::*;

  // source side, pgcb domain
  cq_vec_t     pending_q;
  cq_vec_t     pending_nxt;
  cq_vec_t     arb_reqs;
  cq_vec_t     grant_clear;
  logic        arb_winner_v;
  cq_idx_t     arb_winner;
  xfer_state_t state_q;
  xfer_state_t state_nxt;
  logic        valid_q;
  logic        valid_nxt;
  cq_idx_t     held_cq_q;
  logic        ack_meta_q;
  logic        ack_sync_q;

  // destination side, gated domain
  logic        vld_meta_q;
  logic        vld_sync_q;
  logic        vld_sync_d_q;
  logic        vld_rise;
  logic        dest_v_q;
  cq_idx_t     dest_cq_q;

  // ------------------------------
  // pending vector and arbitration
  // ------------------------------

  // requests reach the arbiter only once the last handshake has
  // gone all the way round and the FSM is back in IDLE
  assign arb_reqs = (state_q == IDLE) ? pending_q : '0;

  wd_rr_arb u_arb (
    .clk      (hqm_pgcb_clk),
    .rst_n    (hqm_pgcb_rst_n),
    .reqs     (arb_reqs),
    .update   (arb_winner_v),
    .winner_v (arb_winner_v),
    .winner   (arb_winner)
  );

  assign grant_clear = arb_winner_v ? (cq_vec_t'(1) << arb_winner) : '0;

  // new expiries are or-ed in after the clear, so an expiry landing on
  // the grant cycle of the same CQ stays pending for another transfer
  // repeats of an already pending CQ fold into its one bit
  assign pending_nxt = (pending_q & ~grant_clear) | expiry;

  // keep the gated clock up while anything waits or is in flight
  assign wd_clkreq = !flr_prep && ((|pending_q) || (|expiry) || (state_q != IDLE));

  // ------------------------------
  // source FSM
  // ------------------------------

  always_comb begin
    state_nxt = state_q;
    valid_nxt = valid_q;
    case (state_q)
      IDLE: begin
        // a grant loads the CQ number and raises the valid level
        if (arb_winner_v) begin
          state_nxt = HOLD;
          valid_nxt = 1'b1;
        end
      end
      HOLD: begin
        // destination has seen the level, drop it
        if (ack_sync_q) begin
          state_nxt = DRAIN;
          valid_nxt = 1'b0;
        end
      end
      DRAIN: begin
        // wait until the low level has come back round
        if (!ack_sync_q) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
        valid_nxt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge hqm_pgcb_clk or negedge hqm_pgcb_rst_n) begin
    if (!hqm_pgcb_rst_n) begin
      pending_q  <= '0;
      state_q    <= IDLE;
      valid_q    <= 1'b0;
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
    end else begin
      pending_q  <= pending_nxt;
      state_q    <= state_nxt;
      valid_q    <= valid_nxt;
      // destination level returns through two flops
      ack_meta_q <= vld_sync_q;
      ack_sync_q <= ack_meta_q;
    end
  end

  // held CQ number crosses as quasi-static data under the valid level
  always_ff @(posedge hqm_pgcb_clk) begin
    if (arb_winner_v) begin
      held_cq_q <= arb_winner;
    end
  end

  // ------------------------------
  // destination side
  // ------------------------------

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      vld_meta_q   <= 1'b0;
      vld_sync_q   <= 1'b0;
      vld_sync_d_q <= 1'b0;
      dest_v_q     <= 1'b0;
    end else begin
      vld_meta_q   <= valid_q;
      vld_sync_q   <= vld_meta_q;
      vld_sync_d_q <= vld_sync_q;
      dest_v_q     <= vld_rise;
    end
  end

  // one cycle on the rising edge of the synchronized valid
  assign vld_rise = vld_sync_q && !vld_sync_d_q;

  // the held number is stable by the time the level arrives here
  always_ff @(posedge hqm_gated_clk) begin
    if (vld_rise) begin
      dest_cq_q <= held_cq_q;
    end
  end

  assign cq_expiry_dest = dest_v_q ? (cq_vec_t'(1) << dest_cq_q) : '0;

  // the number must not move while the destination may still sample it
  a_held_cq_stable: assert property (
    @(posedge hqm_pgcb_clk) disable iff (!hqm_pgcb_rst_n)
    (state_q == HOLD) |=> $stable(held_cq_q)
  );

endmodule

`default_nettype wire

// File: hdl/wd_expiry_status.sv
// ------------------------------
// gated-domain sticky expiry status
// and interrupt level
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module wd_expiry_status (
  input  logic            hqm_gated_clk,
  input  logic            hqm_gated_rst_n,
  input  wd_pkg::cq_vec_t cq_expiry_dest,
  input  wd_pkg::cq_vec_t status_clear,
  output wd_pkg::cq_vec_t expiry_status,
  output logic            wd_irq
);

  import wd_pkg::*;

  cq_vec_t status_q;

  // clear first, then set, so a set on the same cycle survives
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clear) | cq_expiry_dest;
    end
  end

  assign expiry_status = status_q;

  // interrupt stays up while any CQ has an unacknowledged expiry
  assign wd_irq = |status_q;

endmodule

`default_nettype wire

// File: hdl/wd_top.sv
// ------------------------------
// watchdog top: config, timers,
// transfer and status
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module wd_top (
  input  logic            hqm_pgcb_clk,
  input  logic            hqm_pgcb_rst_n,
  input  logic            hqm_gated_clk,
  input  logic            hqm_gated_rst_n,
  input  wd_pkg::cfg_wr_t cfg,
  input  wd_pkg::cq_vec_t cq_activity,
  input  logic            flr_prep,
  input  wd_pkg::cq_vec_t status_clear,
  output logic            wd_clkreq,
  output wd_pkg::cq_vec_t cq_expiry_dest,
  output wd_pkg::cq_vec_t expiry_status,
  output logic            wd_irq
);

  import wd_pkg::*;

  // config to timers, all pgcb domain
  wd_count_t threshold;
  cq_vec_t   enable_mask;
  prescale_t prescale;
  // timer expiry pulses into the transfer
  cq_vec_t   expiry;

  // ------------------------------
  // pgcb domain
  // ------------------------------

  wd_cfg_regs u_cfg_regs (
    .hqm_pgcb_clk   (hqm_pgcb_clk),
    .hqm_pgcb_rst_n (hqm_pgcb_rst_n),
    .cfg            (cfg),
    .threshold      (threshold),
    .enable_mask    (enable_mask),
    .prescale       (prescale)
  );

  wd_cq_timers u_cq_timers (
    .hqm_pgcb_clk   (hqm_pgcb_clk),
    .hqm_pgcb_rst_n (hqm_pgcb_rst_n),
    .threshold      (threshold),
    .enable_mask    (enable_mask),
    .prescale       (prescale),
    .cq_activity    (cq_activity),
    .expiry         (expiry)
  );

  // crossing into the gated domain
  wd_expiry_xfer u_expiry_xfer (
    .hqm_pgcb_clk    (hqm_pgcb_clk),
    .hqm_pgcb_rst_n  (hqm_pgcb_rst_n),
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_n (hqm_gated_rst_n),
    .expiry          (expiry),
    .flr_prep        (flr_prep),
    .wd_clkreq       (wd_clkreq),
    .cq_expiry_dest  (cq_expiry_dest)
  );

  // ------------------------------
  // gated domain
  // ------------------------------

  wd_expiry_status u_expiry_status (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_n (hqm_gated_rst_n),
    .cq_expiry_dest  (cq_expiry_dest),
    .status_clear    (status_clear),
    .expiry_status   (expiry_status),
    .wd_irq          (wd_irq)
  );

endmodule

`default_nettype wire

// File: verification/wd_tb_clkgen.sv
// ------------------------------
// free-running testbench clock
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module wd_tb_clkgen #(
  parameter int period_ns = 8
) (
  output logic clk
);

  // clock starts low, first rising edge after half a period
  initial begin
    clk = 1'b0;
  end

  always begin
    #(period_ns / 2);
    clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verification/wd_tb.sv
// ------------------------------
// watchdog testbench: stimulus, timer
// model, assertions and verdict
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "wd_defs.svh"

module wd_tb;

  import wd_pkg::*;

  localparam int pgcb_period_ns  = 20;
  localparam int gated_period_ns = 8;
  // reset, the five tests and their idle waits take about 2500 pgcb cycles
  // the watchdog allows four times that
  localparam int watchdog_ns = 4 * 2500 * pgcb_period_ns;

  logic        hqm_pgcb_clk;
  logic        hqm_gated_clk;
  logic        hqm_pgcb_rst_n;
  logic        hqm_gated_rst_n;
  cfg_wr_t     cfg;
  cq_vec_t     cq_activity;
  logic        flr_prep;
  cq_vec_t     status_clear;
  logic        wd_clkreq;
  cq_vec_t     cq_expiry_dest;
  cq_vec_t     expiry_status;
  logic        wd_irq;

  string       test_name;
  // CQs that must not show a destination pulse in the running test
  cq_vec_t     never_mask;

  // reference timer state and event counters
  wd_count_t   m_thresh;
  cq_vec_t     m_enable;
  prescale_t   m_prescale;
  prescale_t   m_pre;
  int          m_cnt       [`WD_NUM_CQ];
  int          expect_cnt  [`WD_NUM_CQ];
  int          seen_cnt    [`WD_NUM_CQ];
  int          expect_base [`WD_NUM_CQ];
  int          seen_base   [`WD_NUM_CQ];

  // ------------------------------
  // clocks, resets, DUT
  // ------------------------------

  wd_tb_clkgen #(.period_ns(pgcb_period_ns)) u_pgcb_clkgen (.clk(hqm_pgcb_clk));
  wd_tb_clkgen #(.period_ns(gated_period_ns)) u_gated_clkgen (.clk(hqm_gated_clk));

  // each reset is held for 8 cycles of its own clock
  initial begin
    hqm_pgcb_rst_n = 1'b0;
    repeat (8) @(posedge hqm_pgcb_clk);
    hqm_pgcb_rst_n <= 1'b1;
  end

  initial begin
    hqm_gated_rst_n = 1'b0;
    repeat (8) @(posedge hqm_gated_clk);
    hqm_gated_rst_n <= 1'b1;
  end

  wd_top wd_top_inst (
    .hqm_pgcb_clk    (hqm_pgcb_clk),
    .hqm_pgcb_rst_n  (hqm_pgcb_rst_n),
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_n (hqm_gated_rst_n),
    .cfg             (cfg),
    .cq_activity     (cq_activity),
    .flr_prep        (flr_prep),
    .status_clear    (status_clear),
    .wd_clkreq       (wd_clkreq),
    .cq_expiry_dest  (cq_expiry_dest),
    .expiry_status   (expiry_status),
    .wd_irq          (wd_irq)
  );

  // ------------------------------
  // reference model
  // ------------------------------

  // tick every prescale+1 cycles, quiet enabled CQs count ticks
  // and expire when the count reaches the threshold
  always @(posedge hqm_pgcb_clk or negedge hqm_pgcb_rst_n) begin : timer_model
    logic tick;
    if (!hqm_pgcb_rst_n) begin
      m_thresh   <= '0;
      m_enable   <= '0;
      m_prescale <= '0;
      m_pre      <= '0;
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        m_cnt[i]      <= 0;
        expect_cnt[i] <= 0;
      end
    end else begin
      // a write applies from the cycle after its strobe
      if (cfg.wr) begin
        case (cfg.addr)
          `WD_ADDR_THRESH:   m_thresh   <= cfg.data[`WD_TIMER_W-1:0];
          `WD_ADDR_ENABLE:   m_enable   <= cfg.data[`WD_NUM_CQ-1:0];
          `WD_ADDR_PRESCALE: m_prescale <= cfg.data[`WD_PRESCALE_W-1:0];
          default:           ;
        endcase
      end
      tick = (m_pre == m_prescale);
      m_pre <= tick ? prescale_t'(0) : m_pre + prescale_t'(1);
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        if (!m_enable[i] || cq_activity[i] || (m_thresh == '0)) begin
          m_cnt[i] <= 0;
        end else if (tick && (m_cnt[i] + 1 == int'(m_thresh))) begin
          m_cnt[i]      <= 0;
          expect_cnt[i] <= expect_cnt[i] + 1;
        end else if (tick) begin
          m_cnt[i] <= m_cnt[i] + 1;
        end
      end
    end
  end

  // destination pulses seen per CQ
  always @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        seen_cnt[i] <= 0;
      end
    end else begin
      for (int i = 0; i < `WD_NUM_CQ; i++) begin
        if (cq_expiry_dest[i]) begin
          seen_cnt[i] <= seen_cnt[i] + 1;
        end
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  task automatic fail_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error %s (%s) expected 0x%0h actual 0x%0h", test_name, what, expected,
               actual);
      fail_run();
    end
  endtask

  // one CQ at most per destination cycle
  a_dest_onehot: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    $onehot0(cq_expiry_dest)
  ) else begin
    $display("Error %s expected one-hot pulse actual 0x%0h", test_name,
             $sampled(cq_expiry_dest));
    fail_run();
  end

  a_dest_allowed: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    (cq_expiry_dest & never_mask) == '0
  ) else begin
    $display("Error %s expected no pulse in 0x%0h actual 0x%0h", test_name,
             $sampled(never_mask), $sampled(cq_expiry_dest));
    fail_run();
  end

  // status sets on the cycle after the pulse even with a clear pending
  a_status_sets: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    (|cq_expiry_dest) |=> ((expiry_status & $past(cq_expiry_dest)) == $past(cq_expiry_dest))
  ) else begin
    $display("Error %s expected status bit set actual 0x%0h", test_name,
             $sampled(expiry_status));
    fail_run();
  end

  a_irq_level: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    wd_irq == (|expiry_status)
  ) else begin
    $display("Error %s expected irq %0b actual %0b", test_name,
             |$sampled(expiry_status), $sampled(wd_irq));
    fail_run();
  end

  a_clkreq_flr: assert property (
    @(posedge hqm_pgcb_clk) disable iff (!hqm_pgcb_rst_n)
    flr_prep |-> !wd_clkreq
  ) else begin
    $display("Error %s expected clkreq 0 actual 1", test_name);
    fail_run();
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns while running %s", watchdog_ns, test_name);
    fail_run();
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic write_reg(input logic [1:0] reg_addr, input logic [15:0] reg_data);
    @(posedge hqm_pgcb_clk);
    cfg <= '{wr: 1'b1, addr: reg_addr, data: reg_data};
    @(posedge hqm_pgcb_clk);
    cfg <= '0;
  endtask

  task automatic take_snapshot();
    expect_base = expect_cnt;
    seen_base   = seen_cnt;
  endtask

  // idle means the clock request stayed low for 8 pgcb cycles in a row
  task automatic stop_and_drain();
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    write_reg(`WD_ADDR_ENABLE, 16'h0000);
    while (quiet < 8) begin
      @(posedge hqm_pgcb_clk);
      cycles++;
      quiet = wd_clkreq ? 0 : quiet + 1;
      if (cycles > 600) begin
        $display("transfers did not drain within 600 cycles in %s", test_name);
        fail_run();
      end
    end
  endtask

  // returns on the gated edge that samples the pulse
  task automatic wait_dest_pulse(input int cq, input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(posedge hqm_gated_clk);
      cycles++;
      if (cycles > limit) begin
        $display("no expiry pulse for CQ %0d within %0d cycles in %s", cq, limit, test_name);
        fail_run();
      end
    end while (!cq_expiry_dest[cq]);
  endtask

  task automatic clear_status_bits(input cq_vec_t mask);
    @(posedge hqm_gated_clk);
    status_clear <= mask;
    @(posedge hqm_gated_clk);
    status_clear <= '0;
    @(posedge hqm_gated_clk);
  endtask

  function automatic cq_vec_t rare_activity();
    // each bit high with a chance of one in sixteen
    return cq_vec_t'($urandom & $urandom & $urandom & $urandom);
  endfunction

  // ------------------------------
  // tests
  // ------------------------------

  task automatic expire_one_cq();
    test_name  = "expire_one_cq";
    never_mask = ~cq_vec_t'(16'h0008);
    take_snapshot();
    write_reg(`WD_ADDR_PRESCALE, 16'd1);
    write_reg(`WD_ADDR_THRESH, 16'd5);
    write_reg(`WD_ADDR_ENABLE, 16'h0008);
    wait_dest_pulse(3, 400);
    @(posedge hqm_gated_clk);
    check_value("status", 32'h0008, expiry_status);
    check_value("irq", 1, wd_irq);
    stop_and_drain();
    // a 10-cycle expiry period outlasts one transfer, so nothing merges
    check_value("cq 3 pulses", expect_cnt[3] - expect_base[3], seen_cnt[3] - seen_base[3]);
  endtask

  // CQ 5 is busy every 8 cycles, CQ 6 is quiet, CQ 7 is disabled
  task automatic mask_and_activity();
    test_name  = "mask_and_activity";
    never_mask = cq_vec_t'(16'h00a0);
    take_snapshot();
    write_reg(`WD_ADDR_THRESH, 16'd10);
    write_reg(`WD_ADDR_ENABLE, 16'h0060);
    for (int n = 0; n < 200; n++) begin
      @(posedge hqm_pgcb_clk);
      cq_activity <= (n % 8 == 0) ? cq_vec_t'(16'h0020) : cq_vec_t'(0);
    end
    @(posedge hqm_pgcb_clk);
    cq_activity <= '0;
    stop_and_drain();
    check_value("cq 5 model expiries", 0, expect_cnt[5] - expect_base[5]);
    check_value("cq 6 model expiries", 1, (expect_cnt[6] - expect_base[6]) > 0);
    check_value("cq 6 pulses", expect_cnt[6] - expect_base[6], seen_cnt[6] - seen_base[6]);
  endtask

  // a 320-cycle expiry period outlasts the drain of 16 transfers,
  // so every expiry must come out as its own pulse
  task automatic fairness_all_cqs();
    test_name  = "fairness_all_cqs";
    never_mask = '0;
    take_snapshot();
    write_reg(`WD_ADDR_PRESCALE, 16'd7);
    write_reg(`WD_ADDR_THRESH, 16'd40);
    write_reg(`WD_ADDR_ENABLE, 16'hffff);
    // random activity first spreads the CQ timers apart
    repeat (200) begin
      @(posedge hqm_pgcb_clk);
      cq_activity <= rare_activity();
    end
    @(posedge hqm_pgcb_clk);
    cq_activity <= '0;
    repeat (1000) @(posedge hqm_pgcb_clk);
    stop_and_drain();
    for (int i = 0; i < `WD_NUM_CQ; i++) begin
      check_value($sformatf("cq %0d expired", i), 1, (expect_cnt[i] - expect_base[i]) > 0);
      check_value($sformatf("cq %0d pulses", i), expect_cnt[i] - expect_base[i],
                  seen_cnt[i] - seen_base[i]);
    end
  endtask

  task automatic clkreq_gating();
    int cycles;
    test_name  = "clkreq_gating";
    never_mask = ~cq_vec_t'(16'h0200);
    cycles     = 0;
    @(posedge hqm_pgcb_clk);
    flr_prep <= 1'b1;
    write_reg(`WD_ADDR_THRESH, 16'd2);
    write_reg(`WD_ADDR_ENABLE, 16'h0200);
    // CQ 9 keeps expiring while the request is held off
    repeat (150) @(posedge hqm_pgcb_clk);
    flr_prep <= 1'b0;
    do begin
      @(posedge hqm_pgcb_clk);
      cycles++;
      if (cycles > 100) begin
        $display("clock request never rose after flr_prep dropped in %s", test_name);
        fail_run();
      end
    end while (!wd_clkreq);
    stop_and_drain();
    repeat (20) begin
      @(posedge hqm_pgcb_clk);
      check_value("clkreq when idle", 0, wd_clkreq);
    end
  endtask

  task automatic status_clearing();
    test_name  = "status_clearing";
    never_mask = ~cq_vec_t'(16'h1000);
    // every CQ expired during the fairness test
    @(posedge hqm_gated_clk);
    check_value("status before clear", 32'hffff, expiry_status);
    clear_status_bits(cq_vec_t'(16'h00f0));
    check_value("status after partial clear", 32'hff0f, expiry_status);
    check_value("irq after partial clear", 1, wd_irq);
    clear_status_bits(cq_vec_t'(16'hff0f));
    check_value("status after full clear", 0, expiry_status);
    check_value("irq after full clear", 0, wd_irq);
    // clear for CQ 12 stays up until its pulse has been sampled
    @(posedge hqm_gated_clk);
    status_clear <= cq_vec_t'(16'h1000);
    write_reg(`WD_ADDR_ENABLE, 16'h1000);
    wait_dest_pulse(12, 400);
    status_clear <= '0;
    @(posedge hqm_gated_clk);
    check_value("set against clear", 32'h1000, expiry_status);
    check_value("irq after set", 1, wd_irq);
    stop_and_drain();
    clear_status_bits(cq_vec_t'(16'h1000));
    check_value("irq at end", 0, wd_irq);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    void'($urandom(84545));
    test_name    = "reset";
    never_mask   = '0;
    cfg          = '0;
    cq_activity  = '0;
    flr_prep     = 1'b0;
    status_clear = '0;
    wait (hqm_pgcb_rst_n && hqm_gated_rst_n);
    @(posedge hqm_pgcb_clk);
    check_value("status out of reset", 0, expiry_status);
    check_value("levels and pulses out of reset", 0, {wd_clkreq, wd_irq, cq_expiry_dest});
    expire_one_cq();
    mask_and_activity();
    fairness_all_cqs();
    clkreq_gating();
    status_clearing();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/wd_pkg.sv
hdl/wd_rr_arb.sv
hdl/wd_cfg_regs.sv
hdl/wd_cq_timers.sv
hdl/wd_expiry_xfer.sv
hdl/wd_expiry_status.sv
hdl/wd_top.sv
verification/wd_tb_clkgen.sv
verification/wd_tb.sv

// File: Bender.yml
package:
  name: wd_watchdog

export_include_dirs:
  - hdl

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/wd_pkg.sv
      - hdl/wd_rr_arb.sv
      - hdl/wd_cfg_regs.sv
      - hdl/wd_cq_timers.sv
      - hdl/wd_expiry_xfer.sv
      - hdl/wd_expiry_status.sv
      - hdl/wd_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/wd_tb_clkgen.sv
      - verification/wd_tb.sv
